// File: sim.f
rtl/ifu_pkg.sv
rtl/l1i_way.sv
rtl/l1i_hit_select.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_top.sv
dv/ifu_mem_model.sv
dv/tb_ifu.sv

// File: Makefile
TOP = tb_ifu

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: dv/tb_ifu.sv
`timescale 1ns/10ps

module tb_ifu import ifu_pkg::*; ();

  localparam int    CLK_PERIOD    = 8;
  localparam int    MISS_CYCLES   = 24; // worst case refill of one line.
  localparam int    TOTAL_FETCHES = 43;
  localparam int    NUM_TESTS     = 6;
  localparam int    WATCHDOG_NS   = (TOTAL_FETCHES * MISS_CYCLES + 400) * CLK_PERIOD;
  localparam inst_t JAL           = 32'h0000_006f;
  localparam inst_t BRANCH        = 32'h0000_0063;
  localparam inst_t FENCE_I       = 32'h0000_100f;
  localparam inst_t NEW_WORD      = 32'h0aa0_0013;
  localparam addr_t BR_LINE       = 32'h8000_0200;
  localparam addr_t RESUME_PC     = 32'h8000_0300;
  localparam addr_t F_LINE        = 32'h8000_0410;
  localparam addr_t FENCE_LINE    = 32'h8000_0420;
  localparam addr_t LINE_A        = 32'h8000_1018; // A, B and C share set 3.
  localparam addr_t LINE_B        = 32'h8000_2018;
  localparam addr_t LINE_C        = 32'h8000_3018;

  logic        clk;
  logic        rst;
  rd_req_t     rd_req;
  logic        rd_ready;
  rd_resp_t    rd_resp;
  logic        inst_valid;
  inst_t       inst;
  addr_t       pc;
  logic        inst_ready;
  logic        redirect_valid;
  addr_t       redirect_pc;
  logic [1:0]  ready_dly;
  logic [1:0]  resp_dly;
  logic        ovr_we;
  addr_t       ovr_addr;
  inst_t       ovr_data;
  int unsigned req_count;
  logic [31:0] rng_q;

  addr_t       xfer_pc [$];
  inst_t       xfer_inst [$];
  int unsigned xfer_req [$];
  inst_t       ref_ovr [addr_t];
  logic        stall_q;
  addr_t       stall_pc;
  inst_t       stall_inst;
  int          unstable_cnt;
  string       cur_test;
  int          errors;
  int          test_base;
  int          bad_tests;

  ifu_top dut (
    .clk              (clk),
    .rst              (rst),
    .rd_req_o         (rd_req),
    .rd_ready_i       (rd_ready),
    .rd_resp_i        (rd_resp),
    .inst_valid_o     (inst_valid),
    .inst_o           (inst),
    .pc_o             (pc),
    .inst_ready_i     (inst_ready),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc)
  );

  ifu_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .rd_req_i    (rd_req),
    .rd_ready_o  (rd_ready),
    .rd_resp_o   (rd_resp),
    .ready_dly_i (ready_dly),
    .resp_dly_i  (resp_dly),
    .ovr_we_i    (ovr_we),
    .ovr_addr_i  (ovr_addr),
    .ovr_data_i  (ovr_data),
    .req_count_o (req_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference memory returns the op-imm fill word unless overridden.
  function automatic inst_t expect_word(input addr_t a);
    if (ref_ovr.exists(a)) begin
      return ref_ovr[a];
    end
    return {a[31:7] ^ a[24:0], 7'b0010011};
  endfunction

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    rng_q     <= xorshift32(rng_q);
    ready_dly <= rng_q[1:0];
    resp_dly  <= rng_q[3:2];
  end

  // transfers and hold checks are sampled half a cycle after the inputs move.
  always @(negedge clk) begin
    if (!rst) begin
      if (stall_q && !(inst_valid && inst === stall_inst && pc === stall_pc)) begin
        unstable_cnt++;
      end
      if (inst_valid && inst_ready) begin
        xfer_pc.push_back(pc);
        xfer_inst.push_back(inst);
        xfer_req.push_back(req_count);
      end
      stall_q    = inst_valid && !inst_ready;
      stall_pc   = pc;
      stall_inst = inst;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d transfers", WATCHDOG_NS, xfer_pc.size());
    $display("tests failed");
    $finish;
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
    errors++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_base = errors;
  endtask

  task automatic end_test();
    if (errors != test_base) begin
      bad_tests++;
    end
    $display("%s done, %0d errors", cur_test, errors - test_base);
  endtask

  task automatic poke(input addr_t a, input inst_t d);
    @(posedge clk);
    ovr_we   <= 1'b1;
    ovr_addr <= a;
    ovr_data <= d;
    ref_ovr[a] = d;
    @(posedge clk);
    ovr_we <= 1'b0;
  endtask

  task automatic redirect_to(input addr_t a);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= a;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  task automatic wait_xfers(input int n);
    int cycles;
    cycles = 0;
    while (xfer_pc.size() < n && cycles <= MISS_CYCLES * 8) begin
      @(posedge clk);
      cycles++;
    end
    if (xfer_pc.size() < n) begin
      $display("%s: the DUT made no transfer for %0d cycles", cur_test, cycles);
      errors++;
    end
  endtask

  task automatic check_xfer(input int i, input addr_t exp_pc, input inst_t exp_inst);
    if (xfer_pc[i] !== exp_pc) begin
      report_mismatch("pc", exp_pc, xfer_pc[i]);
    end
    if (xfer_inst[i] !== exp_inst) begin
      report_mismatch("inst", exp_inst, xfer_inst[i]);
    end
  endtask

  task automatic touch_line(input addr_t a, input int unsigned exp_reqs);
    int unsigned base;
    int          n;
    base = req_count;
    n    = xfer_pc.size() + 1;
    redirect_to(a);
    wait_xfers(n);
    check_xfer(n - 1, a, JAL);
    if (req_count - base != exp_reqs) begin
      report_mismatch("requests", exp_reqs, req_count - base);
    end
  endtask

  task automatic test_seq_fetch();
    begin_test("seq_fetch");
    wait_xfers(8);
    for (int i = 0; i < 8; i++) begin
      check_xfer(i, PC_RESET + 4 * i, expect_word(PC_RESET + 4 * i));
      if (xfer_req[i] != 2 * (i / 2 + 1)) begin // two words per new line.
        report_mismatch("requests", 2 * (i / 2 + 1), xfer_req[i]);
      end
    end
    end_test();
  endtask

  task automatic test_refetch();
    int unsigned base;
    begin_test("refetch");
    base = req_count;
    redirect_to(PC_RESET);
    wait_xfers(16);
    for (int i = 0; i < 8; i++) begin
      check_xfer(8 + i, PC_RESET + 4 * i, expect_word(PC_RESET + 4 * i));
    end
    if (req_count != base) begin
      report_mismatch("requests", base, req_count);
    end
    end_test();
  endtask

  task automatic test_ctrl_stall();
    int seen;
    begin_test("ctrl_stall");
    seen = 0;
    redirect_to(BR_LINE);
    wait_xfers(18);
    check_xfer(16, BR_LINE, expect_word(BR_LINE));
    check_xfer(17, BR_LINE + 4, BRANCH);
    repeat (MISS_CYCLES) begin
      @(negedge clk);
      if (inst_valid) begin
        seen++;
      end
    end
    if (seen != 0) begin
      $display("%s: inst_valid_o was high in %0d cycles before the redirect", cur_test, seen);
      errors++;
    end
    redirect_to(RESUME_PC);
    wait_xfers(20);
    check_xfer(18, RESUME_PC, expect_word(RESUME_PC));
    check_xfer(19, RESUME_PC + 4, JAL);
    end_test();
  endtask

  task automatic test_backpressure();
    int cycles;
    begin_test("backpressure");
    cycles = 0;
    redirect_to(PC_RESET);
    while (xfer_pc.size() < 28 && cycles <= MISS_CYCLES * 16) begin
      @(posedge clk);
      inst_ready <= rng_q[7];
      cycles++;
    end
    inst_ready <= 1'b1;
    wait_xfers(28);
    for (int i = 0; i < 8; i++) begin
      check_xfer(20 + i, PC_RESET + 4 * i, expect_word(PC_RESET + 4 * i)); // same pairs as the first run.
    end
    if (unstable_cnt != 0) begin
      $display("%s: outputs moved %0d times while stalled by decode", cur_test, unstable_cnt);
      errors++;
    end
    end_test();
  endtask

  task automatic test_fence_i();
    inst_t       old_word;
    int unsigned base;
    begin_test("fence_i");
    old_word = expect_word(F_LINE);
    redirect_to(F_LINE);
    wait_xfers(30);
    check_xfer(28, F_LINE, old_word);
    poke(F_LINE, NEW_WORD);
    base = req_count;
    redirect_to(F_LINE);
    wait_xfers(32);
    check_xfer(30, F_LINE, old_word); // stale copy still cached.
    if (req_count != base) begin
      report_mismatch("requests", base, req_count);
    end
    redirect_to(FENCE_LINE);
    wait_xfers(34);
    check_xfer(32, FENCE_LINE, FENCE_I);
    check_xfer(33, FENCE_LINE + 4, JAL);
    base = req_count;
    redirect_to(F_LINE);
    wait_xfers(36);
    check_xfer(34, F_LINE, NEW_WORD);
    check_xfer(35, F_LINE + 4, JAL);
    if (req_count != base + 2) begin
      report_mismatch("requests", base + 2, req_count);
    end
    end_test();
  endtask

  task automatic test_replace();
    begin_test("replace");
    touch_line(LINE_A, 2);
    touch_line(LINE_B, 2);
    touch_line(LINE_A, 0);
    touch_line(LINE_C, 2); // evicts B, the least recently used.
    touch_line(LINE_A, 0);
    touch_line(LINE_C, 0);
    touch_line(LINE_B, 2);
    end_test();
  endtask

  initial begin
    rst            = 1'b1;
    inst_ready     = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    ovr_we         = 1'b0;
    ovr_addr       = '0;
    ovr_data       = '0;
    ready_dly      = 2'd0;
    resp_dly       = 2'd0;
    rng_q          = 32'hfd0d_f09f;
    stall_q        = 1'b0;
    stall_pc       = '0;
    stall_inst     = '0;
    unstable_cnt   = 0;
    errors         = 0;
    bad_tests      = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // the fourth line is fetched long after the first poke lands.
    poke(PC_RESET + 28, JAL);
    poke(BR_LINE + 4, BRANCH);
    poke(RESUME_PC + 4, JAL);
    poke(F_LINE + 4, JAL);
    poke(FENCE_LINE, FENCE_I);
    poke(FENCE_LINE + 4, JAL);
    poke(LINE_A, JAL);
    poke(LINE_B, JAL);
    poke(LINE_C, JAL);
    test_seq_fetch();
    test_refetch();
    test_ctrl_stall();
    test_backpressure();
    test_fence_i();
    test_replace();
    $display("%0d tests, %0d with errors, %0d errors in total", NUM_TESTS, bad_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: dv/ifu_mem_model.sv
`timescale 1ns/10ps

module ifu_mem_model import ifu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  rd_req_t     rd_req_i,
  output logic        rd_ready_o,
  output rd_resp_t    rd_resp_o,
  input  logic [1:0]  ready_dly_i,
  input  logic [1:0]  resp_dly_i,
  input  logic        ovr_we_i,
  input  addr_t       ovr_addr_i,
  input  inst_t       ovr_data_i,
  output int unsigned req_count_o
);

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_ACCEPT,
    MS_RESP
  } mem_state_e;

  mem_state_e state_q;
  logic [1:0] cnt_q;
  inst_t      data_q;
  inst_t      ovr_mem [addr_t];

  // every word is an op-imm instruction whose upper bits mix the whole address.
  function automatic inst_t fill_word(input addr_t a);
    return {a[31:7] ^ a[24:0], 7'b0010011};
  endfunction

  assign rd_ready_o = (state_q == MS_ACCEPT) && (cnt_q == 2'd0);

  always_comb begin
    rd_resp_o.valid = (state_q == MS_RESP) && (cnt_q == 2'd0);
    rd_resp_o.data  = data_q;
  end

  always @(posedge clk) begin
    if (ovr_we_i) begin
      ovr_mem[ovr_addr_i] = ovr_data_i; // seen by a request in this same cycle.
    end
    if (rst) begin
      state_q     <= MS_IDLE;
      cnt_q       <= 2'd0;
      data_q      <= '0;
      req_count_o <= 0;
    end else begin
      case (state_q)
        MS_IDLE: begin
          if (rd_req_i.valid) begin
            cnt_q   <= ready_dly_i;
            state_q <= MS_ACCEPT;
          end
        end
        MS_ACCEPT: begin
          if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 2'd1;
          end else if (rd_req_i.valid) begin
            if (ovr_mem.exists(rd_req_i.addr)) begin
              data_q <= ovr_mem[rd_req_i.addr];
            end else begin
              data_q <= fill_word(rd_req_i.addr);
            end
            req_count_o <= req_count_o + 1;
            cnt_q       <= resp_dly_i;
            state_q     <= MS_RESP;
          end
        end
        MS_RESP: begin
          if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 2'd1;
          end else begin
            state_q <= MS_IDLE;
          end
        end
        default: begin
          state_q <= MS_IDLE;
        end
      endcase
    end
  end

endmodule

// File: rtl/ifu_top.sv
`timescale 1ns/10ps

module ifu_top import ifu_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  output rd_req_t  rd_req_o,
  input  logic     rd_ready_i,
  input  rd_resp_t rd_resp_i,

  output logic     inst_valid_o,
  output inst_t    inst_o,
  output addr_t    pc_o,
  input  logic     inst_ready_i,
  input  logic     redirect_valid_i,
  input  addr_t    redirect_pc_i
);

  idx_t                   lk_idx;
  tag_t                   lk_tag;
  off_t                   lk_off;
  refill_t                refill;
  way_vec_t               refill_way;
  logic                   flush;
  lookup_t [NUM_WAYS-1:0] lookup;
  logic                   hit;
  way_vec_t               hit_way;
  inst_t                  hit_data;

  ifu_fetch_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .rd_req_o         (rd_req_o),
    .rd_ready_i       (rd_ready_i),
    .rd_resp_i        (rd_resp_i),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .inst_ready_i     (inst_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .lk_idx_o         (lk_idx),
    .lk_tag_o         (lk_tag),
    .lk_off_o         (lk_off),
    .refill_o         (refill),
    .refill_way_o     (refill_way),
    .flush_o          (flush),
    .hit_i            (hit),
    .hit_way_i        (hit_way),
    .hit_data_i       (hit_data)
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    l1i_way u_way (
      .clk      (clk),
      .rst      (rst),
      .lk_idx_i (lk_idx),
      .lk_tag_i (lk_tag),
      .lk_off_i (lk_off),
      .refill_i (refill),
      .we_i     (refill_way[g]), // only the victim takes the refill.
      .flush_i  (flush),
      .lookup_o (lookup[g])
    );
  end

  l1i_hit_select u_hit_select (
    .lookup_i  (lookup),
    .hit_o     (hit),
    .hit_way_o (hit_way),
    .data_o    (hit_data)
  );

endmodule

// File: rtl/ifu_fetch_ctrl.sv
`timescale 1ns/10ps

module ifu_fetch_ctrl import ifu_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  output rd_req_t  rd_req_o,
  input  logic     rd_ready_i,
  input  rd_resp_t rd_resp_i,

  output logic     inst_valid_o,
  output inst_t    inst_o,
  output addr_t    pc_o,
  input  logic     inst_ready_i,
  input  logic     redirect_valid_i,
  input  addr_t    redirect_pc_i,

  output idx_t     lk_idx_o,
  output tag_t     lk_tag_o,
  output off_t     lk_off_o,
  output refill_t  refill_o,
  output way_vec_t refill_way_o,
  output logic     flush_o,
  input  logic     hit_i,
  input  way_vec_t hit_way_i,
  input  inst_t    hit_data_i
);

  fetch_state_e state_q;
  addr_t        pc_q;
  off_t         off_q;       // refill word being fetched.
  logic [NUM_SETS-1:0] mru_q; // most recently used way per set.

  idx_t pc_idx;
  tag_t pc_tag;
  off_t pc_off;

  assign pc_tag = pc_q[31 -: TAG_W];
  assign pc_idx = pc_q[IDX_W+OFF_W+1 -: IDX_W];
  assign pc_off = pc_q[OFF_W+1 -: OFF_W];

  assign lk_idx_o = pc_idx;
  assign lk_tag_o = pc_tag;
  assign lk_off_o = pc_off;

  // decode side
  logic       xfer;
  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_fence_i;

  assign inst_valid_o = (state_q == FS_LOOKUP) & hit_i;
  assign inst_o       = hit_data_i;
  assign pc_o         = pc_q;
  assign xfer         = inst_valid_o & inst_ready_i;

  assign opcode     = hit_data_i[6:0];
  assign is_ctrl    = (opcode == OP_JAL) | (opcode == OP_JALR) |
                      (opcode == OP_BRANCH) | (opcode == OP_SYSTEM);
  assign is_fence_i = (hit_data_i == INST_FENCE_I);
  assign flush_o    = xfer & is_fence_i; // valid bits drop at this edge.

  // one lru bit per set picks between the two ways
  logic victim;
  logic resp_last;

  assign victim       = ~mru_q[pc_idx];
  assign refill_way_o = way_vec_t'(1) << victim;
  assign resp_last    = (off_q == off_t'(LINE_WORDS - 1));

  // bus
  always_comb begin
    rd_req_o.valid = (state_q == FS_REQ);
    rd_req_o.addr  = {pc_q[31:OFF_W+2], off_q, 2'b00}; // line aligned word address.
  end

  always_comb begin
    refill_o.we   = (state_q == FS_RESP) & rd_resp_i.valid;
    refill_o.idx  = pc_idx;
    refill_o.tag  = pc_tag;
    refill_o.off  = off_q;
    refill_o.data = rd_resp_i.data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FS_LOOKUP;
      pc_q    <= PC_RESET;
      off_q   <= '0;
      mru_q   <= '0;
    end else begin
      unique case (state_q)
        FS_LOOKUP: begin
          if (hit_i) begin
            mru_q[pc_idx] <= hit_way_i[1];
            if (xfer) begin
              if (is_ctrl) begin
                state_q <= FS_WAIT_REDIRECT; // decode owns the next pc.
              end else begin
                pc_q <= pc_q + 32'd4;
              end
            end
          end else begin
            off_q   <= '0;
            state_q <= FS_REQ;
          end
        end
        FS_REQ: begin
          if (rd_ready_i) begin
            state_q <= FS_RESP;
          end
        end
        FS_RESP: begin
          if (rd_resp_i.valid) begin
            if (resp_last) begin
              mru_q[pc_idx] <= victim;
              state_q       <= FS_LOOKUP; // hits next cycle.
            end else begin
              off_q   <= off_q + 1'b1;
              state_q <= FS_REQ;
            end
          end
        end
        FS_WAIT_REDIRECT: begin
          if (redirect_valid_i) begin
            pc_q    <= redirect_pc_i;
            state_q <= FS_LOOKUP;
          end
        end
        default: begin
          state_q <= FS_LOOKUP;
        end
      endcase
    end
  end

  // the address channel may not change or drop while the memory stalls it.
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    rd_req_o.valid && !rd_ready_i |=> rd_req_o.valid && $stable(rd_req_o.addr))
    else $error("ifu: read request changed before rd_ready");

  // a redirect outside the wait state leaves the pc untouched
  a_redirect_ignored: assert property (@(posedge clk) disable iff (rst)
    redirect_valid_i && state_q != FS_WAIT_REDIRECT && !xfer |=> $stable(pc_q))
    else $error("ifu: redirect accepted outside FS_WAIT_REDIRECT");

endmodule

// File: rtl/l1i_hit_select.sv
`timescale 1ns/10ps

module l1i_hit_select import ifu_pkg::*; (
  input  lookup_t [NUM_WAYS-1:0] lookup_i,
  output logic                   hit_o,
  output way_vec_t               hit_way_o,
  output inst_t                  data_o
);

  way_vec_t hit_vec;
  inst_t    data_or;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = lookup_i[w].hit;
    end
  end

  // and-or mux is enough because at most one way hits.
  always_comb begin
    data_or = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        data_or = data_or | lookup_i[w].data;
      end
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec;
  assign data_o    = data_or;

  // a refill only fills a way on a miss of every way, so a line lives in one way.
  always_comb begin
    a_one_hit: assert final ($onehot0(hit_vec))
      else $error("l1i: more than one way hits");
  end

endmodule

// File: rtl/l1i_way.sv
`timescale 1ns/10ps

module l1i_way import ifu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  idx_t    lk_idx_i,
  input  tag_t    lk_tag_i,
  input  off_t    lk_off_i,
  input  refill_t refill_i,
  input  logic    we_i,
  input  logic    flush_i,
  output lookup_t lookup_o
);

  tag_t                tag_mem  [NUM_SETS];
  inst_t               data_mem [NUM_SETS][LINE_WORDS];
  logic [NUM_SETS-1:0] valid_q;

  logic wr;
  logic wr_first;
  logic wr_last;

  assign wr       = refill_i.we & we_i; // the broadcast write lands only in the selected way.
  assign wr_first = (refill_i.off == '0);
  assign wr_last  = (refill_i.off == off_t'(LINE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0; // fence.i.
    end else if (wr) begin
      if (wr_first) begin
        valid_q[refill_i.idx] <= 1'b0; // line is half written.
      end else if (wr_last) begin
        valid_q[refill_i.idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      data_mem[refill_i.idx][refill_i.off] <= refill_i.data;
      if (wr_first) begin
        tag_mem[refill_i.idx] <= refill_i.tag;
      end
    end
  end

  logic  tag_match;
  inst_t rd_word;

  assign tag_match = (tag_mem[lk_idx_i] == lk_tag_i);
  assign rd_word   = data_mem[lk_idx_i][lk_off_i];

  always_comb begin
    lookup_o.hit  = valid_q[lk_idx_i] & tag_match;
    lookup_o.data = rd_word;
  end

endmodule

// File: rtl/ifu_pkg.sv
package ifu_pkg;

  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 4;
  localparam int LINE_WORDS = 2;

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2; // byte offset is not stored.

  localparam logic [31:0] PC_RESET = 32'h8000_0000;

  typedef logic [31:0]         addr_t;
  typedef logic [31:0]         inst_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [IDX_W-1:0]    idx_t;
  typedef logic [OFF_W-1:0]    off_t;
  typedef logic [NUM_WAYS-1:0] way_vec_t;

  // opcodes that stop fetch until decode resolves the next pc
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    FS_LOOKUP,
    FS_REQ,
    FS_RESP,
    FS_WAIT_REDIRECT
  } fetch_state_e;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    inst_t data;
  } rd_resp_t;

  typedef struct packed {
    logic  hit;
    inst_t data;
  } lookup_t;

  typedef struct packed {
    logic  we;
    idx_t  idx;
    tag_t  tag;
    off_t  off;
    inst_t data;
  } refill_t;

endpackage
